// File: build.f
hdl/regmap_pkg.sv
hdl/acq_pkg.sv
hdl/spi_port_if.sv
hdl/spi_reg_set.sv
hdl/spi_port_mux.sv
hdl/sample_acq_pc.sv
hdl/output_mode_mux.sv
hdl/dmm_top.sv
testbench/dmm_top_sva.sv
testbench/tb_dmm_top.sv

// File: hdl/acq_pkg.sv
/* output side: alternate function modes, output vector layout,
   acquisition and activity light constants */
package acq_pkg;

  typedef enum logic [2:0] {
    MODE_DIRECT  = 3'd0,
    MODE_ZERO    = 3'd1,
    MODE_ONES    = 3'd2,
    MODE_PATTERN = 3'd3,
    MODE_ACQ     = 3'd4   // 5..7 drive zero
  } mode_t;

  ////////////////////////////////////////
  // output vector, lsb up
  localparam int unsigned OUT_W      = 25;
  localparam int unsigned LEDS_POS   = 0;
  localparam int unsigned LEDS_W     = 4;
  localparam int unsigned MON_POS    = 4;
  localparam int unsigned MON_W      = 8;
  localparam int unsigned SPI_INT_POS = 12;
  localparam int unsigned MEAS_POS   = 13;
  localparam int unsigned PC1_POS    = 14;
  localparam int unsigned PC2_POS    = 15;
  localparam int unsigned AZMUX_POS  = 16;
  localparam int unsigned AZMUX_W    = 4;
  localparam int unsigned CMPR_POS   = 20;
  localparam int unsigned REFMUX_POS = 21;
  localparam int unsigned REFMUX_W   = 4;

  typedef logic [OUT_W-1:0] out_vec_t;

  localparam int unsigned PC_COUNT_W      = 24;   // precharge length
  localparam int unsigned ACT_HOLD_CYCLES = 64;   // activity led stretch
  localparam int unsigned ACT_CNT_W       = 7;

endpackage

// File: hdl/dmm_top.sv
`timescale 1ns/100ps
/* dmm control fpga top: spi register set, 4094 port routing,
   precharge sequencer and output function mux */
module dmm_top (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              spi_sck_i,
  input  logic                              spi_sdi_i,
  input  logic                              spi_ss_i,
  input  logic                              spi_cs2_i,
  input  logic [regmap_pkg::HW_FLAGS_W-1:0] hw_flags_i,
  input  logic                              u1004_4094_data_i,
  output logic                              spi_sdo_o,
  output logic                              glb_4094_data_o,
  output logic                              glb_4094_clk_o,
  output logic                              glb_4094_strobe_o,
  output logic                              glb_4094_oe_o,
  output logic [acq_pkg::LEDS_W-1:0]        leds_o,
  output logic [acq_pkg::MON_W-1:0]         monitor_o,
  output logic                              spi_interrupt_ctl_o,
  output logic                              meas_complete_o,
  output logic                              sig_pc1_sw_o,
  output logic                              sig_pc2_sw_o,
  output logic [acq_pkg::AZMUX_W-1:0]       azmux_o,
  output logic                              cmpr_latch_o,
  output logic [acq_pkg::REFMUX_W-1:0]      refmux_o
);
  import regmap_pkg::*;
  import acq_pkg::*;

  logic                  reg_sdo, ss_act, cs2_act, sck_sync, sdi_sync;
  reg_word_t             reg_spi_mux, reg_4094, reg_direct, reg_aperture;
  mode_t                 reg_mode;
  logic [PC_COUNT_W-1:0] reg_precharge;
  logic                  acq_pc, acq_led;
  logic [MON_W-1:0]      acq_monitor;
  out_vec_t              out_vec;

  spi_port_if ports_if ();

  spi_reg_set u_reg_set (
    .clk, .rst_n_i, .spi_sck_i, .spi_sdi_i, .spi_ss_i, .spi_cs2_i, .hw_flags_i,
    .spi_sdo_o       (reg_sdo),   // via the port mux
    .ss_act_o        (ss_act),
    .sck_sync_o      (sck_sync),
    .sdi_sync_o      (sdi_sync),
    .cs2_act_o       (cs2_act),
    .reg_spi_mux_o   (reg_spi_mux),
    .reg_4094_o      (reg_4094),
    .reg_mode_o      (reg_mode),
    .reg_direct_o    (reg_direct),
    .reg_aperture_o  (reg_aperture),
    .reg_precharge_o (reg_precharge)
  );

  ////////////////////////////////////////
  // peripheral spi, port 0 is the 4094 chain
  spi_port_mux u_port_mux (
    .cs2_act_i  (cs2_act),
    .sck_i      (sck_sync),
    .sdi_i      (sdi_sync),
    .enable_i   (reg_spi_mux[SPI_PORTS-1:0]),
    .ss_act_i   (ss_act),
    .reg_dout_i (reg_sdo),
    .ports      (ports_if.ctrl),
    .spi_sdo_o  (spi_sdo_o)
  );

  assign ports_if.miso     = {{(SPI_PORTS-1){1'b0}}, u1004_4094_data_i};   // 4094 chain tail
  assign glb_4094_data_o   = ports_if.mosi[0];
  assign glb_4094_clk_o    = ports_if.sck[0];
  assign glb_4094_strobe_o = ports_if.cs[0];
  assign glb_4094_oe_o     = reg_4094[0];   // off until host enables

  sample_acq_pc u_acq (
    .clk, .rst_n_i,
    .aperture_i  (reg_aperture),
    .precharge_i (reg_precharge),
    .pc_ctl_o    (acq_pc),
    .led_o       (acq_led),
    .monitor_o   (acq_monitor)
  );

  output_mode_mux u_mode_mux (
    .clk, .rst_n_i,
    .mode_i        (reg_mode),
    .direct_i      (reg_direct),
    .activity_i    (ss_act | cs2_act),   // either chip select
    .acq_pc_i      (acq_pc),
    .acq_led_i     (acq_led),
    .acq_monitor_i (acq_monitor),
    .out_o         (out_vec)
  );

  ////////////////////////////////////////
  // output vector onto pins
  assign leds_o              = out_vec[LEDS_POS +: LEDS_W];
  assign monitor_o           = out_vec[MON_POS +: MON_W];
  assign spi_interrupt_ctl_o = out_vec[SPI_INT_POS];
  assign meas_complete_o     = out_vec[MEAS_POS];
  assign sig_pc1_sw_o        = out_vec[PC1_POS];
  assign sig_pc2_sw_o        = out_vec[PC2_POS];
  assign azmux_o             = out_vec[AZMUX_POS +: AZMUX_W];
  assign cmpr_latch_o        = out_vec[CMPR_POS];
  assign refmux_o            = out_vec[REFMUX_POS +: REFMUX_W];

endmodule

// File: hdl/output_mode_mux.sv
`timescale 1ns/100ps
/* alternate function select onto the output vector, with test pattern
   counter and stretched activity light */
module output_mode_mux (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  acq_pkg::mode_t            mode_i,
  input  regmap_pkg::reg_word_t     direct_i,
  input  logic                      activity_i,
  input  logic                      acq_pc_i,
  input  logic                      acq_led_i,
  input  logic [acq_pkg::MON_W-1:0] acq_monitor_i,
  output acq_pkg::out_vec_t         out_o
);
  import regmap_pkg::*;
  import acq_pkg::*;

  reg_word_t            pattern_q;
  logic [ACT_CNT_W-1:0] hold_q;
  logic                 act_led;
  reg_word_t            src;

  ////////////////////////////////////////
  // pattern counter and led stretch
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pattern_q <= '0;
      hold_q    <= '0;
    end else begin
      pattern_q <= pattern_q + 1'b1;
      if (activity_i) begin
        hold_q <= ACT_CNT_W'(ACT_HOLD_CYCLES);   // reload while busy
      end else if (hold_q != '0) begin
        hold_q <= hold_q - 1'b1;
      end
    end
  end

  assign act_led = activity_i | (hold_q != '0);

  always_comb begin
    src = '0;
    case (mode_i)
      MODE_DIRECT:  src = {direct_i[REG_W-1:1], act_led};   // led 0 shows spi activity
      MODE_ZERO:    src = '0;
      MODE_ONES:    src = '1;
      MODE_PATTERN: src = pattern_q;
      MODE_ACQ: begin
        src[LEDS_POS]          = acq_led_i;
        src[MON_POS +: MON_W]  = acq_monitor_i;
        src[PC1_POS]           = acq_pc_i;
      end
      default:      src = '0;
    endcase
  end

  // registered, pins glitch free
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_o <= '0;
    end else begin
      out_o <= src[OUT_W-1:0];
    end
  end

endmodule

// File: hdl/regmap_pkg.sv
/* register map of the control FPGA: addresses, word and frame format,
   and the peripheral SPI port constants */
package regmap_pkg;

  ////////////////////////////////////////
  // register words
  localparam int unsigned REG_W      = 32;
  localparam int unsigned REG_ADDR_W = 7;

  typedef logic [REG_W-1:0]      reg_word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  localparam reg_addr_t REG_SPI_MUX   = 7'd0;  // peripheral port enables
  localparam reg_addr_t REG_4094      = 7'd1;  // bit 0 drives 4094 oe
  localparam reg_addr_t REG_MODE      = 7'd2;  // alternate function select
  localparam reg_addr_t REG_DIRECT    = 7'd3;
  localparam reg_addr_t REG_STATUS    = 7'd4;  // read only
  localparam reg_addr_t REG_APERTURE  = 7'd5;
  localparam reg_addr_t REG_PRECHARGE = 7'd6;

  ////////////////////////////////////////
  // spi frame, command byte then data
  localparam int unsigned SPI_CMD_BITS   = 8;   // bit 7 write flag, 6..0 address
  localparam int unsigned SPI_FRAME_BITS = 40;
  localparam int unsigned BIT_CNT_W      = 6;   // saturates, long frames never commit

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;
  localparam int unsigned HW_FLAGS_W  = 3;

  // peripheral ports on chip select 2
  localparam int unsigned SPI_PORTS = 8;
  localparam logic [SPI_PORTS-1:0] SPI_CS_POLARITY = 8'b0000_0001;  // 4094 strobe active hi

endpackage

// File: hdl/sample_acq_pc.sv
`timescale 1ns/100ps
/* precharge sample sequencer: alternates precharge and sample phases
   with lengths taken from the registers */
module sample_acq_pc (
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  regmap_pkg::reg_word_t          aperture_i,
  input  logic [acq_pkg::PC_COUNT_W-1:0] precharge_i,
  output logic                           pc_ctl_o,
  output logic                           led_o,
  output logic [acq_pkg::MON_W-1:0]      monitor_o
);
  import regmap_pkg::*;
  import acq_pkg::*;

  logic             phase_q;   // 1 precharge, 0 sample
  reg_word_t        cnt_q;     // cycles left in phase
  reg_word_t        pre_len, ap_len;
  logic             led_q;
  logic [MON_W-2:0] cyc_q;     // completed cycles

  // zero length treated as one cycle
  assign pre_len = (precharge_i == '0) ? reg_word_t'(1) : reg_word_t'(precharge_i);
  assign ap_len  = (aperture_i == '0) ? reg_word_t'(1) : aperture_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      phase_q <= 1'b1;   // start in precharge
      cnt_q   <= reg_word_t'(1);
      led_q   <= 1'b0;
      cyc_q   <= '0;
    end else if (cnt_q <= reg_word_t'(1)) begin
      phase_q <= ~phase_q;
      if (phase_q) begin
        cnt_q <= ap_len;    // into sample
      end else begin
        cnt_q <= pre_len;   // new precharge, cycle done
        led_q <= ~led_q;
        cyc_q <= cyc_q + 1'b1;
      end
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign pc_ctl_o  = phase_q;
  assign led_o     = led_q;
  assign monitor_o = {cyc_q, phase_q};

endmodule

// File: hdl/spi_port_if.sv
`timescale 1ns/100ps
/* bundle of the eight peripheral spi ports behind chip select 2 */
interface spi_port_if;
  import regmap_pkg::*;

  logic [SPI_PORTS-1:0] sck;   // one bit per port
  logic [SPI_PORTS-1:0] mosi;
  logic [SPI_PORTS-1:0] cs;    // polarity per port
  logic [SPI_PORTS-1:0] miso;

  // the mux drives the port side
  modport ctrl (
    output sck, mosi, cs,
    input  miso
  );

  // attached devices answer on miso
  modport periph (
    input  sck, mosi, cs,
    output miso
  );

endinterface

// File: hdl/spi_port_mux.sv
`timescale 1ns/100ps
/* routes chip select 2 traffic onto the enabled peripheral ports
   and picks the sdo source */
module spi_port_mux (
  input  logic                             cs2_act_i,
  input  logic                             sck_i,
  input  logic                             sdi_i,
  input  logic [regmap_pkg::SPI_PORTS-1:0] enable_i,
  input  logic                             ss_act_i,
  input  logic                             reg_dout_i,   // register set shift out
  spi_port_if.ctrl                         ports,
  output logic                             spi_sdo_o
);
  import regmap_pkg::*;

  logic [SPI_PORTS-1:0] act_vec;
  logic                 port_miso;

  assign act_vec = {SPI_PORTS{cs2_act_i}};

  // disabled ports held low
  assign ports.sck  = enable_i & act_vec & {SPI_PORTS{sck_i}};
  assign ports.mosi = enable_i & act_vec & {SPI_PORTS{sdi_i}};
  assign ports.cs   = enable_i & (act_vec ^ ~SPI_CS_POLARITY);   // per port polarity

  assign port_miso = |(ports.miso & enable_i);

  // register reads win over port traffic
  always_comb begin
    if (ss_act_i) begin
      spi_sdo_o = reg_dout_i;
    end else if (cs2_act_i) begin
      spi_sdo_o = port_miso;
    end else begin
      spi_sdo_o = 1'b0;   // bus idle
    end
  end

endmodule

// File: hdl/spi_reg_set.sv
`timescale 1ns/100ps
/* host register set: spi slave sampled in the clk domain, frame decode,
   writable registers and the read only status word */
module spi_reg_set (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              spi_sck_i,
  input  logic                              spi_sdi_i,
  input  logic                              spi_ss_i,      // active low
  input  logic                              spi_cs2_i,     // active low
  input  logic [regmap_pkg::HW_FLAGS_W-1:0] hw_flags_i,
  output logic                              spi_sdo_o,
  output logic                              ss_act_o,
  output logic                              sck_sync_o,
  output logic                              sdi_sync_o,
  output logic                              cs2_act_o,
  output regmap_pkg::reg_word_t             reg_spi_mux_o,
  output regmap_pkg::reg_word_t             reg_4094_o,
  output acq_pkg::mode_t                    reg_mode_o,
  output regmap_pkg::reg_word_t             reg_direct_o,
  output regmap_pkg::reg_word_t             reg_aperture_o,
  output logic [acq_pkg::PC_COUNT_W-1:0]    reg_precharge_o
);
  import regmap_pkg::*;
  import acq_pkg::*;

  logic [3:0]              meta_q, sync_q;   // {cs2, ss, sdi, sck}
  logic                    sck_q, ss_q;
  logic                    sck_rise, sck_fall, ss_end;
  logic [BIT_CNT_W-1:0]    bit_cnt_q;
  reg_word_t               rx_q, tx_q;
  logic [SPI_CMD_BITS-1:0] cmd_q, cmd_next;
  reg_word_t               rd_word, status_w;
  reg_word_t               reg_spi_mux_q, reg_4094_q, reg_mode_q;
  reg_word_t               reg_direct_q, reg_aperture_q, reg_precharge_q;

  ////////////////////////////////////////
  // pin synchronizers and edges
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      meta_q <= 4'b1100;   // selects idle high
      sync_q <= 4'b1100;
      sck_q  <= 1'b0;
      ss_q   <= 1'b1;
    end else begin
      meta_q <= {spi_cs2_i, spi_ss_i, spi_sdi_i, spi_sck_i};
      sync_q <= meta_q;
      sck_q  <= sync_q[0];
      ss_q   <= sync_q[2];
    end
  end

  assign sck_sync_o = sync_q[0];
  assign sdi_sync_o = sync_q[1];
  assign ss_act_o   = ~sync_q[2];
  assign cs2_act_o  = ~sync_q[3];
  assign sck_rise   = sync_q[0] & ~sck_q;
  assign sck_fall   = ~sync_q[0] & sck_q;
  assign ss_end     = sync_q[2] & ~ss_q;   // ss released, commit point

  ////////////////////////////////////////
  // frame bit counter
  always_ff @(posedge clk) begin
    if (!rst_n_i || !ss_act_o) begin
      bit_cnt_q <= '0;
    end else if (sck_rise && bit_cnt_q != '1) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  assign cmd_next = {rx_q[SPI_CMD_BITS-2:0], sdi_sync_o};   // byte incl. current bit
  assign status_w = {{(REG_W - HW_FLAGS_W - 8){1'b0}}, hw_flags_i, STATUS_MAGIC};

  // read value, addressed by the finishing command byte
  always_comb begin
    case (reg_addr_t'(cmd_next[REG_ADDR_W-1:0]))
      REG_SPI_MUX:   rd_word = reg_spi_mux_q;
      REG_4094:      rd_word = reg_4094_q;
      REG_MODE:      rd_word = reg_mode_q;
      REG_DIRECT:    rd_word = reg_direct_q;
      REG_STATUS:    rd_word = status_w;
      REG_APERTURE:  rd_word = reg_aperture_q;
      REG_PRECHARGE: rd_word = reg_precharge_q;
      default:       rd_word = '0;
    endcase
  end

  // shift registers, sample on rise, sdo moves on fall
  always_ff @(posedge clk) begin
    if (!ss_act_o) begin
      tx_q <= '0;
    end else if (sck_rise) begin
      rx_q <= {rx_q[REG_W-2:0], sdi_sync_o};
      if (bit_cnt_q == BIT_CNT_W'(SPI_CMD_BITS - 1)) begin
        cmd_q <= cmd_next;
        tx_q  <= rd_word;   // msb out before first data rise
      end
    end else if (sck_fall && bit_cnt_q > BIT_CNT_W'(SPI_CMD_BITS)) begin
      tx_q <= {tx_q[REG_W-2:0], 1'b0};
    end
  end

  assign spi_sdo_o = tx_q[REG_W-1];

  ////////////////////////////////////////
  // write commit at end of a full frame
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      reg_spi_mux_q   <= '0;
      reg_4094_q      <= '0;
      reg_mode_q      <= '0;
      reg_direct_q    <= '0;
      reg_aperture_q  <= '0;
      reg_precharge_q <= '0;
    end else if (ss_end && bit_cnt_q == BIT_CNT_W'(SPI_FRAME_BITS) &&
                 cmd_q[SPI_CMD_BITS-1]) begin
      case (reg_addr_t'(cmd_q[REG_ADDR_W-1:0]))
        REG_SPI_MUX:   reg_spi_mux_q   <= rx_q;
        REG_4094:      reg_4094_q      <= rx_q;
        REG_MODE:      reg_mode_q      <= rx_q;
        REG_DIRECT:    reg_direct_q    <= rx_q;
        REG_APERTURE:  reg_aperture_q  <= rx_q;
        REG_PRECHARGE: reg_precharge_q <= rx_q;
        default: ;   // status and unknown, dropped
      endcase
    end
  end

  assign reg_spi_mux_o   = reg_spi_mux_q;
  assign reg_4094_o      = reg_4094_q;
  assign reg_mode_o      = mode_t'(reg_mode_q[$bits(mode_t)-1:0]);
  assign reg_direct_o    = reg_direct_q;
  assign reg_aperture_o  = reg_aperture_q;
  assign reg_precharge_o = reg_precharge_q[PC_COUNT_W-1:0];

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the dmm control testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_dmm_top \
  -f build.f -o sim_dmm \
  && ./obj_dir/sim_dmm \
  || { echo "simulation run returned an error"; exit 1; }

// File: testbench/dmm_top_sva.sv
`timescale 1ns/100ps
/* pin rule assertions for the dmm control top */
module dmm_top_sva (
  input logic        clk,
  input logic        rst_n_i,
  input logic        spi_ss_i,
  input logic        spi_cs2_i,
  input logic        spi_sdo_i,
  input logic        port0_en_i,
  input logic        strobe_i,
  input logic [29:0] pins_i      // every output pin
);

  // both selects high two samples back means idle after the synchronizer
  sdo_idle_a : assert property (@(posedge clk) disable iff (!rst_n_i)
    ($past(spi_ss_i, 2) && $past(spi_cs2_i, 2)) |-> !spi_sdo_i)
    else $error("sdo driven with no chip select active");

  reset_low_a : assert property (@(posedge clk)
    !rst_n_i |=> (pins_i == '0))
    else $error("output pin high after a reset cycle");

  // strobe is active high, follows cs2 through two flops
  strobe_a : assert property (@(posedge clk) disable iff (!rst_n_i)
    port0_en_i |-> (strobe_i == !$past(spi_cs2_i, 2)))
    else $error("4094 strobe does not follow chip select 2");

endmodule

bind dmm_top dmm_top_sva u_sva (
  .clk        (clk),
  .rst_n_i    (rst_n_i),
  .spi_ss_i   (spi_ss_i),
  .spi_cs2_i  (spi_cs2_i),
  .spi_sdo_i  (spi_sdo_o),
  .port0_en_i (reg_spi_mux[0]),
  .strobe_i   (glb_4094_strobe_o),
  .pins_i     ({spi_sdo_o, glb_4094_data_o, glb_4094_clk_o, glb_4094_strobe_o,
                glb_4094_oe_o, refmux_o, cmpr_latch_o, azmux_o, sig_pc2_sw_o,
                sig_pc1_sw_o, meas_complete_o, spi_interrupt_ctl_o, monitor_o, leds_o})
);

// File: testbench/tb_dmm_top.sv
`timescale 1ns/100ps
/* testbench for the dmm control top: spi host frames against a shadow
   register model, output modes, acquisition timing and the 4094 port */
module tb_dmm_top;
  import regmap_pkg::*;
  import acq_pkg::*;

  localparam int unsigned HALF_CYC  = 6;   // sck half period in clk cycles
  localparam int unsigned FRAME_CYC = 500;
  localparam int unsigned CYC_LIMIT = 40 * FRAME_CYC + 20000;
  localparam int unsigned PC_P      = 7;   // precharge length under test
  localparam int unsigned PC_A      = 11;  // aperture length under test
  localparam reg_addr_t   BAD_ADDR  = 7'h55;

  logic                  clk, rst_n_i;
  logic                  spi_sck_i, spi_sdi_i, spi_ss_i, spi_cs2_i;
  logic [HW_FLAGS_W-1:0] hw_flags_i;
  logic                  u1004_4094_data_i;
  logic                  spi_sdo_o, glb_4094_data_o, glb_4094_clk_o;
  logic                  glb_4094_strobe_o, glb_4094_oe_o;
  logic [LEDS_W-1:0]     leds_o;
  logic [MON_W-1:0]      monitor_o;
  logic                  spi_interrupt_ctl_o, meas_complete_o;
  logic                  sig_pc1_sw_o, sig_pc2_sw_o;
  logic [AZMUX_W-1:0]    azmux_o;
  logic                  cmpr_latch_o;
  logic [REFMUX_W-1:0]   refmux_o;

  out_vec_t    pins;                    // pins regathered in out_vec order
  reg_word_t   shadow [0:127];          // host view of the register map
  logic [31:0] lcg_state  = 32'd39870;
  int unsigned cycles     = 0;
  logic        pin_chk_en = 1'b0;
  mode_t       exp_mode   = MODE_DIRECT;
  reg_word_t   exp_direct = '0;

  dmm_top u_dut (.*);

  assign pins = {refmux_o, cmpr_latch_o, azmux_o, sig_pc2_sw_o, sig_pc1_sw_o,
                 meas_complete_o, spi_interrupt_ctl_o, monitor_o, leds_o};

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  // run length guard
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYC_LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", CYC_LIMIT);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  ////////////////////////////////////////
  // models and helpers
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];   // upper half of the state
  endfunction

  function automatic reg_word_t rand_word();
    logic [15:0] hi;
    hi = lcg_next();
    return {hi, lcg_next()};
  endfunction

  function automatic logic writable(input reg_addr_t addr);
    return addr inside {REG_SPI_MUX, REG_4094, REG_MODE, REG_DIRECT,
                        REG_APERTURE, REG_PRECHARGE};
  endfunction

  // expected read word for an address
  function automatic reg_word_t ref_reg(input reg_addr_t addr);
    if (addr == REG_STATUS) begin
      return reg_word_t'({hw_flags_i, STATUS_MAGIC});
    end
    if (writable(addr)) begin
      return shadow[addr];
    end
    return '0;   // unmapped
  endfunction

  // expected pins for the static modes
  function automatic out_vec_t predict_out(input mode_t m, input reg_word_t direct);
    case (m)
      MODE_DIRECT: return {direct[OUT_W-1:1], 1'b1};   // led 0 lit from the mode write
      MODE_ONES:   return '1;
      default:     return '0;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] exp_v,
                       input logic [31:0] got_v);
    if (exp_v !== got_v) begin
      $display("ERR %0t %s exp %0h got %0h", $time, name, exp_v, got_v);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // pin compare while a static mode is held
  always @(negedge clk) begin
    if (pin_chk_en) begin
      check("out_vec pins", predict_out(exp_mode, exp_direct), pins);
    end
  end

  task automatic tick(input int unsigned n);
    repeat (n) @(posedge clk);
    #1;   // drive point after the edge
  endtask

  ////////////////////////////////////////
  // mode 0 spi master where sel2 picks chip select 2
  task automatic spi_frame(input logic sel2, input logic port_on, input logic [7:0] cmd,
                           input reg_word_t data, output reg_word_t rd);
    logic [SPI_FRAME_BITS-1:0] tx;
    logic [15:0]               r;
    logic                      miso_bit;
    int                        i;
    tx = {cmd, data};
    rd = '0;
    if (sel2) begin
      spi_cs2_i = 1'b0;
    end else begin
      spi_ss_i = 1'b0;
    end
    tick(HALF_CYC);
    for (i = SPI_FRAME_BITS - 1; i >= 0; i--) begin
      r = lcg_next();
      miso_bit = r[15];
      spi_sdi_i = tx[i];
      u1004_4094_data_i = miso_bit;   // 4094 chain tail
      tick(HALF_CYC);
      if (i < REG_W) begin
        rd = {rd[REG_W-2:0], spi_sdo_o};   // sampled just before the rise
      end
      if (sel2) begin
        check("glb_4094_data_o", port_on & tx[i], glb_4094_data_o);
        check("glb_4094_clk_o", 1'b0, glb_4094_clk_o);
        check("glb_4094_strobe_o", port_on, glb_4094_strobe_o);
        check("spi_sdo_o", port_on & miso_bit, spi_sdo_o);
      end
      spi_sck_i = 1'b1;
      tick(HALF_CYC);
      if (sel2) begin
        check("glb_4094_clk_o", port_on, glb_4094_clk_o);
      end
      spi_sck_i = 1'b0;
    end
    tick(HALF_CYC);
    spi_ss_i          = 1'b1;
    spi_cs2_i         = 1'b1;
    spi_sdi_i         = 1'b0;
    u1004_4094_data_i = 1'b0;
    tick(6);   // writes reach the pins by now
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_word_t data);
    reg_word_t rd;
    spi_frame(1'b0, 1'b0, {1'b1, addr}, data, rd);
    if (writable(addr)) begin
      shadow[addr] = data;
    end
  endtask

  task automatic read_check(input reg_addr_t addr);
    reg_word_t rd;
    spi_frame(1'b0, 1'b0, {1'b0, addr}, '0, rd);
    check($sformatf("spi_sdo_o read of reg %0d", addr), ref_reg(addr), rd);
  endtask

  task automatic hold_mode(input logic [2:0] m);
    write_reg(REG_MODE, reg_word_t'(m));
    exp_mode   = mode_t'(m);
    pin_chk_en = 1'b1;
    tick(24);
    pin_chk_en = 1'b0;
  endtask

  ////////////////////////////////////////
  // main sequence
  initial begin
    logic [15:0]      r;
    reg_word_t        rd, data;
    reg_addr_t        addr;
    out_vec_t         prev;
    int unsigned      n;
    logic [MON_W-2:0] exp_cyc;
    logic             exp_led;
    rst_n_i           = 1'b0;
    spi_sck_i         = 1'b0;
    spi_sdi_i         = 1'b0;
    spi_ss_i          = 1'b1;
    spi_cs2_i         = 1'b1;
    u1004_4094_data_i = 1'b0;
    r = lcg_next();
    hw_flags_i = r[HW_FLAGS_W-1:0];
    foreach (shadow[k]) shadow[k] = '0;
    tick(5);
    rst_n_i = 1'b1;
    tick(2);

    // every pin low out of reset
    check("out_vec pins", '0, pins);
    check("spi_sdo_o", 1'b0, spi_sdo_o);
    check("glb_4094_data_o", 1'b0, glb_4094_data_o);
    check("glb_4094_clk_o", 1'b0, glb_4094_clk_o);
    check("glb_4094_strobe_o", 1'b0, glb_4094_strobe_o);
    check("glb_4094_oe_o", 1'b0, glb_4094_oe_o);
    read_check(REG_STATUS);

    // random writes with readback
    repeat (20) begin
      r = lcg_next();
      addr = reg_addr_t'(r % 6);
      if (addr >= REG_STATUS) begin
        addr = addr + 1'b1;   // skip the status word
      end
      data = rand_word();
      if (addr == REG_APERTURE || addr == REG_PRECHARGE) begin
        data = data & 32'h3F;   // short phases
      end
      write_reg(addr, data);
      read_check(addr);
    end
    write_reg(REG_STATUS, '1);
    read_check(REG_STATUS);
    write_reg(BAD_ADDR, rand_word());
    read_check(BAD_ADDR);

    // static output modes
    write_reg(REG_DIRECT, rand_word());
    exp_direct = shadow[REG_DIRECT];
    hold_mode(MODE_ZERO);
    hold_mode(MODE_ONES);
    hold_mode(MODE_DIRECT);
    hold_mode(3'd5);
    write_reg(REG_MODE, reg_word_t'(MODE_PATTERN));
    prev = pins;
    repeat (24) begin
      tick(1);
      check("pattern pins", out_vec_t'(prev + 1), pins);
      prev = pins;
    end

    // precharge sequencer on the pc1 pin
    write_reg(REG_PRECHARGE, PC_P);
    write_reg(REG_APERTURE, PC_A);
    write_reg(REG_MODE, reg_word_t'(MODE_ACQ));
    while (sig_pc1_sw_o) tick(1);
    while (!sig_pc1_sw_o) tick(1);   // start of a full precharge
    exp_cyc = monitor_o[MON_W-1:1];
    exp_led = leds_o[0];
    repeat (2) begin
      check("monitor_o", {exp_cyc, 1'b1}, monitor_o);   // phase in bit 0
      check("leds_o", {3'b000, exp_led}, leds_o);
      n = 0;
      while (sig_pc1_sw_o) begin
        n++;
        tick(1);
      end
      check("sig_pc1_sw_o high cycles", PC_P, n);
      n = 0;
      while (!sig_pc1_sw_o) begin
        n++;
        tick(1);
      end
      check("sig_pc1_sw_o low cycles", PC_A, n);
      exp_cyc = exp_cyc + 1'b1;   // one completed cycle per period
      exp_led = ~exp_led;
    end

    // chip select 2 onto the 4094 port
    write_reg(REG_SPI_MUX, 32'd1);
    spi_frame(1'b1, 1'b1, {1'b1, REG_SPI_MUX}, '0, rd);
    read_check(REG_SPI_MUX);   // port traffic must not write
    write_reg(REG_SPI_MUX, '0);
    spi_frame(1'b1, 1'b0, {1'b1, REG_4094}, rand_word(), rd);

    // 4094 output enable
    write_reg(REG_4094, 32'd1);
    check("glb_4094_oe_o", 1'b1, glb_4094_oe_o);
    write_reg(REG_4094, 32'd0);
    check("glb_4094_oe_o", 1'b0, glb_4094_oe_o);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule
